// ==== radix4_divider.f ====
div_types_pkg.sv
div_ctrl_pkg.sv
radix4_stage.sv
div_datapath.sv
div_sequencer.sv
div_result_reg.sv
radix4_divider.sv
radix4_divider_tb.sv

// ==== radix4_divider_tb.sv ====
// Assumes the 32-bit default with two digits per cycle; random operands use a fixed seed
`timescale 1ns/100ps

module radix4_divider_tb;

    localparam int WIDTH        = div_types_pkg::DEFAULT_WIDTH;
    localparam int DIGITS       = div_types_pkg::DEFAULT_DIGITS;
    localparam int N            = div_ctrl_pkg::iter_count(WIDTH, DIGITS);
    localparam int LATENCY      = N + 2;
    localparam int RANDOM_OPS   = 200;
    localparam int DIRECTED_OPS = 14;
    localparam int SEED         = 16;
    localparam int HALF_PERIOD  = 5;

    typedef logic [WIDTH-1:0] word_t;

    logic  ctl_clk;
    logic  reset;
    logic  trigger;
    word_t a;
    word_t b;
    word_t q;
    word_t r;
    logic  ready;
    logic  done;

    int checks       = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycle_count  = 0;

    // Expected results in accept order
    word_t exp_q_queue[$];
    word_t exp_r_queue[$];
    int    accept_queue[$];

    word_t last_q    = '0;
    word_t last_r    = '0;

    radix4_divider #(
        .DIV_WIDTH        (WIDTH),
        .DIGITS_PER_CYCLE (DIGITS)
    ) i_radix4_divider (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .a       (a),
        .b       (b),
        .q       (q),
        .r       (r),
        .ready   (ready),
        .done    (done)
    );

    initial begin
        ctl_clk = 1'b0;
        forever #HALF_PERIOD ctl_clk = ~ctl_clk;
    end

    // Divide by zero gives all ones and r = a
    function automatic word_t model_quotient(input word_t x, input word_t y);
        return (y == '0) ? '1 : x / y;
    endfunction

    function automatic word_t model_remainder(input word_t x, input word_t y);
        return (y == '0) ? x : x % y;
    endfunction

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic report_counts();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
    endtask

    // Called at a falling edge; returns at the falling edge after the accept
    task automatic start_division(input word_t op_a, input word_t op_b);
        while (!ready) begin
            @(negedge ctl_clk);
        end
        a       = op_a;
        b       = op_b;
        trigger = 1'b1;
        @(negedge ctl_clk);
        trigger = 1'b0;
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        do begin
            @(negedge ctl_clk);
            waited++;
        end while (!done && waited <= LATENCY + 2);
        assert (done) else report_problem("timed out waiting for done");
    endtask

    task automatic wait_until_ready();
        do begin
            @(negedge ctl_clk);
        end while (!ready);
    endtask

    // done is a single-cycle pulse
    assert property (@(posedge ctl_clk) disable iff (!reset) done |=> !done)
        else report_problem("done stayed high for more than one cycle");

    // Accept happens on the edge where trigger meets ready
    always @(posedge ctl_clk) begin
        cycle_count = cycle_count + 1;
        if (reset && trigger && ready) begin
            exp_q_queue.push_back(model_quotient(a, b));
            exp_r_queue.push_back(model_remainder(a, b));
            accept_queue.push_back(cycle_count);
        end
    end

    always @(negedge ctl_clk) begin : check_outputs
        int    acc;
        word_t exp_q;
        word_t exp_r;
        if (reset) begin
            if (done) begin
                assert (accept_queue.size() > 0)
                    else report_problem("done pulse with no division pending");
                if (accept_queue.size() > 0) begin
                    acc   = accept_queue.pop_front();
                    exp_q = exp_q_queue.pop_front();
                    exp_r = exp_r_queue.pop_front();
                    compare_word("done latency", word_t'(cycle_count - acc), LATENCY);
                    compare_word("q", q, exp_q);
                    compare_word("r", r, exp_r);
                    last_q = exp_q;
                    last_r = exp_r;
                end
            end else begin
                // Results hold between done pulses
                compare_word("q", q, last_q);
                compare_word("r", r, last_r);
                if (accept_queue.size() > 0 && cycle_count - accept_queue[0] > LATENCY) begin
                    report_problem("no done pulse within the expected latency");
                    acc   = accept_queue.pop_front();
                    exp_q = exp_q_queue.pop_front();
                    exp_r = exp_r_queue.pop_front();
                end
            end
        end
    end

    initial begin : stimulus
        word_t op_a;
        word_t op_b;
        int    i;
        reset   = 1'b0;
        trigger = 1'b0;
        a       = '0;
        b       = '0;
        op_a    = $urandom(SEED);
        repeat (8) @(negedge ctl_clk);
        reset = 1'b1;
        @(negedge ctl_clk);
        compare_word("ready", ready, 1);
        compare_word("done", done, 0);
        compare_word("q", q, 0);
        compare_word("r", r, 0);

        for (i = 0; i < RANDOM_OPS; i++) begin
            op_a = $urandom;
            op_b = $urandom >> ($urandom % WIDTH);
            start_division(op_a, op_b);
            wait_for_done();
        end

        // Zero divisor
        start_division($urandom, '0);
        wait_for_done();
        start_division('1, '0);
        wait_for_done();

        // Small dividend, then divisors that push x2 and x3 past the word
        start_division(32'd1234, 32'd98765);
        wait_for_done();
        start_division(32'hFFFF_FFFE, 32'hFFFF_FFFF);
        wait_for_done();
        start_division(32'hFFFF_FFF0, 32'h8000_0001);
        wait_for_done();
        start_division(32'hFFFF_FFFF, 32'h5555_5556);
        wait_for_done();
        start_division(32'hC000_0000, 32'h4000_0001);
        wait_for_done();
        start_division('1, 32'd1);
        wait_for_done();

        // Triggers while busy must be dropped
        start_division(32'h8765_4321, 32'd1000);
        repeat (3) begin
            compare_word("ready", ready, 0);
            a       = 32'h789A_BCDE;
            b       = 32'd3;
            trigger = 1'b1;
            @(negedge ctl_clk);
        end
        trigger = 1'b0;
        wait_for_done();

        // Back-to-back starts from the done state
        start_division($urandom, $urandom >> 8);
        repeat (4) begin
            wait_until_ready();
            start_division($urandom, $urandom >> ($urandom % WIDTH));
            compare_word("ready", ready, 0);
        end
        wait_for_done();

        repeat (LATENCY + 4) @(negedge ctl_clk);
        assert (accept_queue.size() == 0)
            else report_problem("divisions still pending at the end of the run");

        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat ((RANDOM_OPS + DIRECTED_OPS) * (N + 4) + 50) @(posedge ctl_clk);
        $display("Watchdog expired before the tests finished");
        other_errors++;
        report_counts();
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== radix4_divider.sv ====
// Unsigned divide; trigger is accepted only while ready, and b = 0 gives q all ones, r = a
`timescale 1ns/100ps

module radix4_divider #(
    parameter int DIV_WIDTH        = div_types_pkg::DEFAULT_WIDTH,
    parameter int DIGITS_PER_CYCLE = div_types_pkg::DEFAULT_DIGITS
) (
    input  logic                 ctl_clk,
    input  logic                 reset,
    input  logic                 trigger,
    input  logic [DIV_WIDTH-1:0] a,
    input  logic [DIV_WIDTH-1:0] b,
    output logic [DIV_WIDTH-1:0] q,
    output logic [DIV_WIDTH-1:0] r,
    output logic                 ready,
    output logic                 done
);

    logic                   load;
    logic                   step;
    logic                   finish;
    logic [2*DIV_WIDTH-1:0] work_value;

    // Control
    div_sequencer #(
        .DIV_WIDTH        (DIV_WIDTH),
        .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
    ) i_div_sequencer (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .load    (load),
        .step    (step),
        .finish  (finish)
    );

    // Digit iteration
    div_datapath #(
        .DIV_WIDTH        (DIV_WIDTH),
        .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
    ) i_div_datapath (
        .ctl_clk    (ctl_clk),
        .reset      (reset),
        .load       (load),
        .step       (step),
        .a          (a),
        .b          (b),
        .work_value (work_value)
    );

    // Output registers
    div_result_reg #(
        .DIV_WIDTH (DIV_WIDTH)
    ) i_div_result_reg (
        .ctl_clk    (ctl_clk),
        .reset      (reset),
        .finish     (finish),
        .work_value (work_value),
        .q          (q),
        .r          (r),
        .done       (done)
    );

endmodule

// ==== div_result_reg.sv ====
// done is a single-cycle pulse with no hold; q and r keep the last result until the next one
`timescale 1ns/100ps

module div_result_reg #(
    parameter int DIV_WIDTH = div_types_pkg::DEFAULT_WIDTH
) (
    input  logic                   ctl_clk,
    input  logic                   reset,
    input  logic                   finish,
    input  logic [2*DIV_WIDTH-1:0] work_value,
    output logic [DIV_WIDTH-1:0]   q,
    output logic [DIV_WIDTH-1:0]   r,
    output logic                   done
);

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            q    <= '0;
            r    <= '0;
            done <= 1'b0;
        end else if (finish) begin
            // Quotient in the low half, remainder in the high half
            q    <= work_value[DIV_WIDTH-1:0];
            r    <= work_value[2*DIV_WIDTH-1:DIV_WIDTH];
            done <= 1'b1;
        end else begin
            done <= 1'b0;
        end
    end

endmodule

// ==== div_sequencer.sv ====
// Fixed latency of iter_count + 2 cycles from accept to done; no abort once started
`timescale 1ns/100ps

module div_sequencer #(
    parameter int DIV_WIDTH        = div_types_pkg::DEFAULT_WIDTH,
    parameter int DIGITS_PER_CYCLE = div_types_pkg::DEFAULT_DIGITS
) (
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic load,
    output logic step,
    output logic finish
);

    localparam int ITERS      = div_ctrl_pkg::iter_count(DIV_WIDTH, DIGITS_PER_CYCLE);
    localparam int COUNT_BITS = div_ctrl_pkg::count_bits(DIV_WIDTH, DIGITS_PER_CYCLE);

    localparam logic [COUNT_BITS-1:0] LAST_COUNT = COUNT_BITS'(ITERS);

    div_ctrl_pkg::div_state_t state_q;
    div_ctrl_pkg::div_state_t state_next;
    logic [COUNT_BITS-1:0]    count_q;

    assign ready = (state_q == div_ctrl_pkg::ST_IDLE)
                   || (state_q == div_ctrl_pkg::ST_DONE);

    // Only accept point for new operands
    assign load   = trigger && ready;
    assign step   = (state_q == div_ctrl_pkg::ST_CALC) && (count_q != LAST_COUNT);
    assign finish = (state_q == div_ctrl_pkg::ST_DONE);

    always_comb begin
        state_next = state_q;
        case (state_q)
            div_ctrl_pkg::ST_IDLE: begin
                if (load) begin
                    state_next = div_ctrl_pkg::ST_CALC;
                end
            end
            div_ctrl_pkg::ST_CALC: begin
                if (count_q == LAST_COUNT) begin
                    state_next = div_ctrl_pkg::ST_DONE;
                end
            end
            div_ctrl_pkg::ST_DONE: begin
                // Back-to-back start skips idle
                if (load) begin
                    state_next = div_ctrl_pkg::ST_CALC;
                end else begin
                    state_next = div_ctrl_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = div_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state_q <= div_ctrl_pkg::ST_IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_next;
            if (load) begin
                count_q <= '0;
            end else if (step) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

// ==== div_datapath.sv ====
// Operands are captured only on load; a zero divisor yields all-ones quotient and r = a
`timescale 1ns/100ps

module div_datapath #(
    parameter int DIV_WIDTH        = div_types_pkg::DEFAULT_WIDTH,
    parameter int DIGITS_PER_CYCLE = div_types_pkg::DEFAULT_DIGITS
) (
    input  logic                   ctl_clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   step,
    input  logic [DIV_WIDTH-1:0]   a,
    input  logic [DIV_WIDTH-1:0]   b,
    output logic [2*DIV_WIDTH-1:0] work_value
);

    // Quotient bits produced per working cycle
    localparam int SHIFT = DIGITS_PER_CYCLE * div_types_pkg::DIGIT_BITS;

    typedef logic [DIV_WIDTH-1:0]   word_t;
    typedef logic [2*DIV_WIDTH-1:0] work_t;

    word_t divisor_q;
    work_t work_q;
    work_t work_next;

    logic [DIV_WIDTH:0]   divisor_x2;
    logic [DIV_WIDTH+1:0] divisor_x3;

    word_t                   rem_chain [DIGITS_PER_CYCLE+1];
    div_types_pkg::q_digit_t digit_chain [DIGITS_PER_CYCLE];
    logic [SHIFT-1:0]        digits_packed;
    word_t                   low_next;

    // Multiples formed once for all stages
    assign divisor_x2 = {divisor_q, 1'b0};
    assign divisor_x3 = {1'b0, divisor_x2} + {2'b00, divisor_q};

    // Remainder half feeds the first stage
    assign rem_chain[0] = work_q[2*DIV_WIDTH-1:DIV_WIDTH];

    genvar g;
    for (g = 0; g < DIGITS_PER_CYCLE; g = g + 1) begin : g_digit
        radix4_stage #(
            .DIV_WIDTH (DIV_WIDTH)
        ) i_radix4_stage (
            .partial_rem (rem_chain[g]),
            .next_bits   (work_q[DIV_WIDTH-1-g*div_types_pkg::DIGIT_BITS -:
                                 div_types_pkg::DIGIT_BITS]),
            .divisor_x1  (divisor_q),
            .divisor_x2  (divisor_x2),
            .divisor_x3  (divisor_x3),
            .new_rem     (rem_chain[g+1]),
            .digit       (digit_chain[g])
        );

        // First stage gives the most significant digit
        assign digits_packed[SHIFT-1-g*div_types_pkg::DIGIT_BITS -:
                             div_types_pkg::DIGIT_BITS] = digit_chain[g];
    end

    // Consumed dividend bits leave at the top, new digits enter at the bottom
    assign low_next  = (work_q[DIV_WIDTH-1:0] << SHIFT) | word_t'(digits_packed);
    assign work_next = {rem_chain[DIGITS_PER_CYCLE], low_next};

    always_ff @(posedge ctl_clk) begin
        if (load) begin
            divisor_q <= b;
        end
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            work_q <= '0;
        end else if (load) begin
            work_q <= {word_t'('0), a};
        end else if (step) begin
            work_q <= work_next;
        end
    end

    assign work_value = work_q;

endmodule

// ==== radix4_stage.sv ====
// Combinational only; the partial remainder must stay below 2**(DIV_WIDTH-2) before the shift
`timescale 1ns/100ps

module radix4_stage #(
    parameter int DIV_WIDTH = div_types_pkg::DEFAULT_WIDTH
) (
    input  logic [DIV_WIDTH-1:0]    partial_rem,
    input  div_types_pkg::q_digit_t next_bits,
    input  logic [DIV_WIDTH-1:0]    divisor_x1,
    input  logic [DIV_WIDTH:0]      divisor_x2,
    input  logic [DIV_WIDTH+1:0]    divisor_x3,
    output logic [DIV_WIDTH-1:0]    new_rem,
    output div_types_pkg::q_digit_t digit
);

    logic [DIV_WIDTH+1:0] extended;
    logic [DIV_WIDTH-1:0] shifted;

    // One guard bit on top catches the borrow
    logic [DIV_WIDTH:0] diff_x1;
    logic [DIV_WIDTH:0] diff_x2;
    logic [DIV_WIDTH:0] diff_x3;

    div_types_pkg::mult_sel_t fits;

    // Bring in the next two dividend bits
    assign extended = {partial_rem, next_bits};
    assign shifted  = extended[DIV_WIDTH-1:0];

    // All three trial subtractions run in parallel
    assign diff_x1 = {1'b0, shifted} - {1'b0, divisor_x1};
    assign diff_x2 = {1'b0, shifted} - {1'b0, divisor_x2[DIV_WIDTH-1:0]};
    assign diff_x3 = {1'b0, shifted} - {1'b0, divisor_x3[DIV_WIDTH-1:0]};

    // A multiple wider than the word can never fit
    assign fits[div_types_pkg::SEL_X1] = !diff_x1[DIV_WIDTH];
    assign fits[div_types_pkg::SEL_X2] = !diff_x2[DIV_WIDTH]
                                         && !divisor_x2[DIV_WIDTH];
    assign fits[div_types_pkg::SEL_X3] = !diff_x3[DIV_WIDTH]
                                         && !divisor_x3[DIV_WIDTH+1]
                                         && !divisor_x3[DIV_WIDTH];

    // Priority select, largest multiple first
    always_comb begin
        if (fits[div_types_pkg::SEL_X3]) begin
            new_rem = diff_x3[DIV_WIDTH-1:0];
            digit   = div_types_pkg::DIGIT_X3;
        end else if (fits[div_types_pkg::SEL_X2]) begin
            new_rem = diff_x2[DIV_WIDTH-1:0];
            digit   = div_types_pkg::DIGIT_X2;
        end else if (fits[div_types_pkg::SEL_X1]) begin
            new_rem = diff_x1[DIV_WIDTH-1:0];
            digit   = div_types_pkg::DIGIT_X1;
        end else begin
            // Nothing fits, restore
            new_rem = shifted;
            digit   = div_types_pkg::DIGIT_X0;
        end
    end

endmodule

// ==== div_ctrl_pkg.sv ====
// Counts assume the width divides evenly by twice the digits retired per cycle
package div_ctrl_pkg;

    // Controller states; the encoding 2'b11 is never entered
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_CALC = 2'b01,
        ST_DONE = 2'b10
    } div_state_t;

    // Working cycles for one division
    function automatic int iter_count(input int width, input int digits);
        return width / (2 * digits);
    endfunction

    // Counter width able to hold 0 to iter_count inclusive
    function automatic int count_bits(input int width, input int digits);
        int n;
        n = iter_count(width, digits);
        if (n < 1) begin
            return 1;
        end
        return $clog2(n + 1);
    endfunction

endpackage

// ==== div_types_pkg.sv ====
// Unsigned operands only; widths must be a multiple of twice the digits per cycle
package div_types_pkg;

    // Defaults used when the top level is not overridden
    localparam int DEFAULT_WIDTH  = 32;
    localparam int DEFAULT_DIGITS = 2;

    // One radix-4 digit carries two bits
    localparam int DIGIT_BITS = 2;

    // Divisor multiples tried per digit: x1, x2, x3
    localparam int MULT_COUNT = 3;

    typedef logic [DIGIT_BITS-1:0] q_digit_t;

    // One flag per multiple, bit 0 is x1
    typedef logic [MULT_COUNT-1:0] mult_sel_t;

    // Digit values picked by the priority selector
    localparam q_digit_t DIGIT_X0 = 2'd0;
    localparam q_digit_t DIGIT_X1 = 2'd1;
    localparam q_digit_t DIGIT_X2 = 2'd2;
    localparam q_digit_t DIGIT_X3 = 2'd3;

    // Bit positions inside mult_sel_t
    localparam int SEL_X1 = 0;
    localparam int SEL_X2 = 1;
    localparam int SEL_X3 = 2;

endpackage
